/* common/cpu_pkg.sv */
// Shared types, opcodes and reset constants for the 8-bit processor
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  word_t;         // Data, register and address value
    typedef logic [1:0]  reg_idx_t;
    typedef logic [15:0] cycle_count_t;  // Retired instruction count

    // Instruction field ir[7:4]
    typedef enum logic [3:0] {
        NOP   = 4'b0000,
        ADD   = 4'b0001,
        ADDI  = 4'b0010,
        SUB   = 4'b0011,
        MUL   = 4'b0100,
        NEG   = 4'b0110,
        BGEZ0 = 4'b1000,
        BGEZ1 = 4'b1001,
        MOVE  = 4'b1010,
        STORE = 4'b1011,
        LOAD  = 4'b1100,
        LOADI = 4'b1101,
        JUMP  = 4'b1110
    } opcode_t;

    localparam logic [3:0] HALT_CODE = 4'b1111;  // Sub-code under NOP

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_MUL, ALU_NEG} alu_op_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    localparam word_t RESET_PC = 8'd33;

    // Power-on register contents
    localparam word_t R0_INIT = 8'd0;
    localparam word_t R1_INIT = 8'd1;
    localparam word_t R2_INIT = 8'd12;
    localparam word_t R3_INIT = 8'd11;

endpackage

`default_nettype wire

/* core/alu.sv */
// Arithmetic unit for add, subtract, multiply and negate with a registered result
`default_nettype none

module alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alu_en,
    input  cpu_pkg::alu_op_t  alu_op,
    input  cpu_pkg::word_t    a,
    input  cpu_pkg::word_t    b,
    output cpu_pkg::word_t    alu_lo,
    output cpu_pkg::word_t    alu_hi,
    output logic              alu_ready
);
    import cpu_pkg::*;

    logic        busy;     // Request already taken
    logic [15:0] product;
    word_t       lo_nxt;

    assign product = a * b;

    always_comb begin
        case (alu_op)
            ALU_ADD: lo_nxt = a + b;
            ALU_SUB: lo_nxt = a - b;
            ALU_MUL: lo_nxt = product[7:0];
            default: lo_nxt = 8'd0 - a;
        endcase
    end

    // One ready pulse per held request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            alu_ready <= 1'b0;
        end else begin
            busy      <= alu_en;
            alu_ready <= alu_en && !busy;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_en && !busy) begin
            alu_lo <= lo_nxt;
            alu_hi <= product[15:8];
        end
    end

endmodule

`default_nettype wire

/* core/control_unit.sv */
// Control unit sequencing fetch, decode, execute and write-back for each instruction
`default_nettype none

module control_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  cpu_pkg::word_t        ir,
    input  logic                  ir_valid,
    input  cpu_pkg::word_t        pc,
    input  cpu_pkg::word_t        rd_data,
    input  cpu_pkg::word_t        rs_data,
    input  cpu_pkg::word_t        r0_data,
    input  cpu_pkg::word_t        r3_data,
    input  logic                  alu_ready,
    input  cpu_pkg::word_t        alu_lo,
    input  cpu_pkg::word_t        alu_hi,
    input  logic                  ls_done,
    input  cpu_pkg::word_t        ls_rdata,
    output logic                  fetch_start,
    output logic                  pc_next,
    output logic                  pc_load,
    output cpu_pkg::word_t        pc_target,
    output cpu_pkg::reg_idx_t     rd_sel,
    output cpu_pkg::reg_idx_t     rs_sel,
    output logic                  wa_en,
    output cpu_pkg::reg_idx_t     wa_sel,
    output cpu_pkg::word_t        wa_data,
    output logic                  wb_en,
    output cpu_pkg::word_t        wb_data,
    output logic                  alu_en,
    output cpu_pkg::alu_op_t      alu_op,
    output logic                  ls_start,
    output logic                  ls_write,
    output cpu_pkg::word_t        ls_addr,
    output cpu_pkg::word_t        ls_wdata,
    output logic                  halt,
    output cpu_pkg::cycle_count_t cc
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, EXECUTE, WAIT_ALU, WAIT_MEM, HALTED} state_t;

    state_t  state, state_nxt;
    opcode_t opcode;
    word_t   imm;
    logic    is_alu, is_mem, is_halt, retire;

    assign opcode  = opcode_t'(ir[7:4]);
    assign rd_sel  = ir[3:2];
    assign rs_sel  = ir[1:0];
    assign imm     = {6'b0, ir[1:0]};
    assign is_alu  = opcode inside {ADD, SUB, MUL, NEG};
    assign is_mem  = opcode inside {STORE, LOAD};
    assign is_halt = (opcode == NOP) && (ir[3:0] == HALT_CODE);

    assign ls_write  = (opcode == STORE);
    assign ls_addr   = ls_write ? rd_data : {2'b00, r3_data[1:0], ir[3:0]};
    assign ls_wdata  = rs_data;
    assign pc_target = (opcode == JUMP) ? rd_data : {2'b00, ir[4], ir[3:0], 1'b0};
    assign wb_data   = alu_hi;  // High byte of MUL into r1

    always_comb begin
        case (opcode)
            SUB:     alu_op = ALU_SUB;
            MUL:     alu_op = ALU_MUL;
            NEG:     alu_op = ALU_NEG;
            default: alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        state_nxt = state;
        pc_next   = 1'b0;
        pc_load   = 1'b0;
        wa_en     = 1'b0;
        wa_sel    = rd_sel;
        wa_data   = rs_data;  // MOVE source
        wb_en     = 1'b0;
        alu_en    = 1'b0;
        ls_start  = 1'b0;
        retire    = 1'b0;
        case (state)
            IDLE:  if (en) state_nxt = FETCH;
            FETCH: if (ir_valid) state_nxt = EXECUTE;
            EXECUTE: begin
                if (is_alu) begin
                    alu_en    = 1'b1;
                    state_nxt = WAIT_ALU;
                end else if (is_mem) begin
                    ls_start  = 1'b1;
                    state_nxt = WAIT_MEM;
                end else begin
                    retire    = 1'b1;
                    state_nxt = is_halt ? HALTED : FETCH;
                    case (opcode)
                        ADDI: begin
                            wa_en   = 1'b1;
                            wa_data = rd_data + imm;
                            pc_next = 1'b1;
                        end
                        LOADI: begin
                            wa_en   = 1'b1;
                            wa_data = imm;
                            pc_next = 1'b1;
                        end
                        MOVE: begin
                            wa_en   = 1'b1;
                            pc_next = 1'b1;
                        end
                        JUMP: begin
                            wa_en   = 1'b1;
                            wa_sel  = 2'd3;     // Link register
                            wa_data = pc + 8'd1;
                            pc_load = 1'b1;
                        end
                        BGEZ0, BGEZ1: begin
                            pc_load = !r0_data[7];  // Signed r0 >= 0
                            pc_next = r0_data[7];
                        end
                        default: pc_next = !is_halt;
                    endcase
                end
            end
            WAIT_ALU: begin
                alu_en = !alu_ready;
                if (alu_ready) begin
                    wa_en     = 1'b1;
                    wa_sel    = 2'd0;
                    wa_data   = alu_lo;
                    wb_en     = (opcode == MUL);
                    pc_next   = 1'b1;
                    retire    = 1'b1;
                    state_nxt = FETCH;
                end
            end
            WAIT_MEM: begin
                if (ls_done) begin
                    wa_en     = !ls_write;  // LOAD result to r0
                    wa_sel    = 2'd0;
                    wa_data   = ls_rdata;
                    pc_next   = 1'b1;
                    retire    = 1'b1;
                    state_nxt = FETCH;
                end
            end
            HALTED:  state_nxt = HALTED;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            fetch_start <= 1'b0;
            halt        <= 1'b0;
            cc          <= '0;
        end else begin
            state       <= state_nxt;
            fetch_start <= (state == IDLE && en) || (retire && !is_halt);
            if (retire)
                cc <= cc + 16'd1;
            if (retire && is_halt)
                halt <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* core/fetch_unit.sv */
// Instruction fetch with program counter and instruction register
`default_nettype none

module fetch_unit #(
    parameter cpu_pkg::word_t START_PC = cpu_pkg::RESET_PC
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_start,
    input  logic              pc_next,
    input  logic              pc_load,
    input  cpu_pkg::word_t    pc_target,
    input  logic              grant,
    input  logic              rvalid,
    input  cpu_pkg::word_t    rdata,
    output cpu_pkg::mem_req_t req,
    output cpu_pkg::word_t    pc,
    output cpu_pkg::word_t    ir,
    output logic              ir_valid
);
    logic req_valid;

    // Read at pc, held until granted
    assign req = '{valid: req_valid, write: 1'b0, addr: pc, wdata: 8'h00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= START_PC;
            req_valid <= 1'b0;
            ir_valid  <= 1'b0;
        end else begin
            if (pc_load)
                pc <= pc_target;
            else if (pc_next)
                pc <= pc + 8'd1;
            if (fetch_start)
                req_valid <= 1'b1;
            else if (grant)
                req_valid <= 1'b0;
            ir_valid <= rvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid)
            ir <= rdata;
    end

endmodule

`default_nettype wire

/* core/register_file.sv */
// Four user registers with two read ports, a general write port and an r1 write port
`default_nettype none

module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rd_sel,
    input  cpu_pkg::reg_idx_t rs_sel,
    input  logic              wa_en,
    input  cpu_pkg::reg_idx_t wa_sel,
    input  cpu_pkg::word_t    wa_data,
    input  logic              wb_en,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::word_t    rd_data,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    r0_data,
    output cpu_pkg::word_t    r3_data
);
    import cpu_pkg::*;

    word_t regs [4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs[0] <= R0_INIT;
            regs[1] <= R1_INIT;
            regs[2] <= R2_INIT;
            regs[3] <= R3_INIT;
        end else begin
            if (wa_en)
                regs[wa_sel] <= wa_data;
            if (wb_en)
                regs[1] <= wb_data;  // MUL high byte
        end
    end

    assign rd_data = regs[rd_sel];
    assign rs_data = regs[rs_sel];
    assign r0_data = regs[0];  // Branch condition
    assign r3_data = regs[3];  // LOAD page bits

endmodule

`default_nettype wire

/* design/cpu_top.sv */
// Processor top level joining the core and the shared memory port
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t START_PC = cpu_pkg::RESET_PC
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  cpu_pkg::word_t        mem_rdata,
    output cpu_pkg::mem_req_t     mem_req,
    output logic                  halt,
    output cpu_pkg::cycle_count_t cc
);
    import cpu_pkg::*;

    word_t    ir, pc, pc_target;
    logic     ir_valid, fetch_start, pc_next, pc_load;
    reg_idx_t rd_sel, rs_sel, wa_sel;
    word_t    rd_data, rs_data, r0_data, r3_data;
    logic     wa_en, wb_en;
    word_t    wa_data, wb_data;
    logic     alu_en, alu_ready;
    alu_op_t  alu_op;
    word_t    alu_lo, alu_hi;
    logic     ls_start, ls_write, ls_done;
    word_t    ls_addr, ls_wdata, ls_rdata;
    mem_req_t fetch_req, ls_req;
    logic     fetch_grant, ls_grant, fetch_rvalid, ls_rvalid;
    word_t    arb_rdata;

    control_unit u_ctrl (
        .clk, .rst_n, .en, .ir, .ir_valid, .pc,
        .rd_data, .rs_data, .r0_data, .r3_data,
        .alu_ready, .alu_lo, .alu_hi, .ls_done, .ls_rdata,
        .fetch_start, .pc_next, .pc_load, .pc_target, .rd_sel, .rs_sel,
        .wa_en, .wa_sel, .wa_data, .wb_en, .wb_data, .alu_en, .alu_op,
        .ls_start, .ls_write, .ls_addr, .ls_wdata, .halt, .cc
    );

    register_file u_regs (
        .clk, .rst_n, .rd_sel, .rs_sel, .wa_en, .wa_sel, .wa_data,
        .wb_en, .wb_data, .rd_data, .rs_data, .r0_data, .r3_data
    );

    alu u_alu (
        .clk, .rst_n, .alu_en, .alu_op,
        .a(rd_data), .b(rs_data),  // Operands straight from the decoded fields
        .alu_lo, .alu_hi, .alu_ready
    );

    fetch_unit #(.START_PC(START_PC)) u_fetch (
        .clk, .rst_n, .fetch_start, .pc_next, .pc_load, .pc_target,
        .grant(fetch_grant), .rvalid(fetch_rvalid), .rdata(arb_rdata),
        .req(fetch_req), .pc, .ir, .ir_valid
    );

    load_store_unit u_lsu (
        .clk, .rst_n, .ls_start, .ls_write, .ls_addr, .ls_wdata,
        .grant(ls_grant), .rvalid(ls_rvalid), .rdata(arb_rdata),
        .req(ls_req), .ls_done, .ls_rdata
    );

    mem_arbiter u_arb (
        .clk, .rst_n, .fetch_req, .ls_req, .mem_rdata, .mem_req,
        .fetch_grant, .ls_grant, .fetch_rvalid, .ls_rvalid, .rdata(arb_rdata)
    );

endmodule

`default_nettype wire

/* memory/load_store_unit.sv */
// Load/store unit holding one data access until the memory port takes it
`default_nettype none

module load_store_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ls_start,
    input  logic              ls_write,
    input  cpu_pkg::word_t    ls_addr,
    input  cpu_pkg::word_t    ls_wdata,
    input  logic              grant,
    input  logic              rvalid,
    input  cpu_pkg::word_t    rdata,
    output cpu_pkg::mem_req_t req,
    output logic              ls_done,
    output cpu_pkg::word_t    ls_rdata
);
    import cpu_pkg::*;

    logic  req_valid;
    logic  req_write;
    word_t req_addr;
    word_t req_wdata;

    assign req = '{valid: req_valid, write: req_write, addr: req_addr, wdata: req_wdata};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            ls_done   <= 1'b0;
        end else begin
            if (ls_start)
                req_valid <= 1'b1;
            else if (grant)
                req_valid <= 1'b0;
            ls_done <= (grant && req_write) || rvalid;  // Write done at grant
        end
    end

    always_ff @(posedge clk) begin
        if (ls_start) begin
            req_write <= ls_write;
            req_addr  <= ls_addr;
            req_wdata <= ls_wdata;
        end
        if (rvalid)
            ls_rdata <= rdata;
    end

endmodule

`default_nettype wire

/* memory/mem_arbiter.sv */
// Fixed-priority arbiter sharing the memory port between fetch and load/store
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::mem_req_t fetch_req,
    input  cpu_pkg::mem_req_t ls_req,
    input  cpu_pkg::word_t    mem_rdata,
    output cpu_pkg::mem_req_t mem_req,
    output logic              fetch_grant,
    output logic              ls_grant,
    output logic              fetch_rvalid,
    output logic              ls_rvalid,
    output cpu_pkg::word_t    rdata
);
    // Load/store always wins
    assign ls_grant    = ls_req.valid;
    assign fetch_grant = fetch_req.valid && !ls_req.valid;
    assign mem_req     = ls_req.valid ? ls_req : fetch_req;

    assign rdata = mem_rdata;  // Shared, qualified by the rvalid strobes

    // Owner of the read in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_rvalid <= 1'b0;
            ls_rvalid    <= 1'b0;
        end else begin
            fetch_rvalid <= fetch_grant && !fetch_req.write;
            ls_rvalid    <= ls_grant && !ls_req.write;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cpu_tb -f sim.f -o cpu_tb_sim

./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

# Exit status follows the search result
grep -qx "TESTS PASSED" sim.log

/* sim.f */
+incdir+sim
common/cpu_pkg.sv
core/register_file.sv
core/alu.sv
core/fetch_unit.sv
core/control_unit.sv
memory/load_store_unit.sv
memory/mem_arbiter.sv
design/cpu_top.sv
sim/cpu_tb.sv

/* sim/isa_model.svh */
// ISA reference model, directed programs and random program generator for the processor testbench
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

word_t        image [256];        // Memory contents for the next run
word_t        store_addr_q [$];   // Model stores, oldest first
word_t        store_data_q [$];
cycle_count_t exp_count;

// Background bytes differ for every address, program placed at RESET_PC
function automatic void place_code(word_t code [$]);
    for (int a = 0; a < 256; a++)
        image[a] = word_t'(a * 29) ^ 8'hA5;
    foreach (code[i])
        image[RESET_PC + i] = code[i];
endfunction

// ADD, SUB, MUL and NEG on the reset values, results stored at r2 and r3
function automatic void alu_program();
    word_t code [$];
    code = '{{ADD, 4'b1011}, {STORE, 4'b1000}, {SUB, 4'b1011}, {STORE, 4'b1000},
             {MUL, 4'b1011}, {STORE, 4'b1000}, {STORE, 4'b1101},
             {MUL, 4'b0000}, {STORE, 4'b1000}, {STORE, 4'b1101},  // Nonzero high byte
             {NEG, 4'b1000}, {STORE, 4'b1000}, {NOP, HALT_CODE}};
    place_code(code);
endfunction

function automatic void load_store_program();
    word_t code [$];
    code = '{{LOADI, 4'b0111}, {ADDI, 4'b0110}, {MOVE, 4'b1001}, {STORE, 4'b1001},
             {LOADI, 4'b1100}, {LOAD, 4'b0101}, {STORE, 4'b1100},
             {LOAD, 4'b1001}, {STORE, 4'b1000},
             {LOADI, 4'b1110}, {LOAD, 4'b1010}, {STORE, 4'b1100},  // Reads a program byte
             {NOP, HALT_CODE}};
    place_code(code);
endfunction

// Markers at r2 on each path, wrong paths store r2 itself or halt early
function automatic void branch_program();
    word_t code [$];
    code = '{{BGEZ1, 4'd2}, {STORE, 4'b1010}, {NOP, HALT_CODE},
             {LOADI, 4'b0110}, {STORE, 4'b1001}, {NEG, 4'b0100},
             {BGEZ0, 4'd3}, {LOADI, 4'b0111}, {STORE, 4'b1001},
             {ADD, 4'b1011}, {ADD, 4'b0000}, {JUMP, 4'b0000},
             {STORE, 4'b1010}, {STORE, 4'b1011}, {NOP, HALT_CODE}};
    place_code(code);
endfunction

// Random body of 4 to 20 instructions, then HALT
function automatic void random_program();
    logic [3:0] plain_ops [10];
    word_t      code [$];
    word_t      w;
    plain_ops = '{NOP, ADD, ADDI, SUB, MUL, NEG, MOVE, STORE, LOAD, LOADI};
    repeat ($urandom_range(20, 4)) begin
        w = word_t'($urandom);
        if ($urandom_range(9, 0) > 2)
            w[7:4] = plain_ops[$urandom_range(9, 0)];  // Rest keep any opcode
        code.push_back(w);
    end
    code.push_back({NOP, HALT_CODE});
    place_code(code);
endfunction

// Runs the image from RESET_PC, returns 1 when HALT retires within the limit
function automatic bit run_model(int limit);
    word_t       m [256];
    word_t       r [4];
    word_t       pc, ins, nxt;
    reg_idx_t    rd, rs;
    logic [15:0] prod;
    m = image;
    r = '{R0_INIT, R1_INIT, R2_INIT, R3_INIT};
    pc = RESET_PC;
    store_addr_q.delete();
    store_data_q.delete();
    exp_count = '0;
    for (int n = 0; n < limit; n++) begin
        ins = m[pc];
        rd = ins[3:2];
        rs = ins[1:0];
        nxt = pc + 8'd1;
        exp_count = exp_count + 16'd1;
        if (ins == {NOP, HALT_CODE})
            return 1'b1;
        case (ins[7:4])
            ADD:   r[0] = r[rd] + r[rs];
            SUB:   r[0] = r[rd] - r[rs];
            NEG:   r[0] = 8'd0 - r[rd];
            ADDI:  r[rd] = r[rd] + 8'(ins[1:0]);
            LOADI: r[rd] = 8'(ins[1:0]);
            MOVE:  r[rd] = r[rs];
            LOAD:  r[0] = m[{2'b00, r[3][1:0], ins[3:0]}];
            MUL: begin
                prod = 16'(r[rd]) * 16'(r[rs]);
                r[0] = prod[7:0];
                r[1] = prod[15:8];
            end
            STORE: begin
                store_addr_q.push_back(r[rd]);
                store_data_q.push_back(r[rs]);
                m[r[rd]] = r[rs];
            end
            JUMP: begin
                nxt  = r[rd];        // Target read before the link write
                r[3] = pc + 8'd1;
            end
            BGEZ0, BGEZ1: if (!r[0][7]) nxt = {2'b00, ins[4], ins[3:0], 1'b0};
            default: ;
        endcase
        pc = nxt;
    end
    return 1'b0;
endfunction

`endif

/* sim/cpu_tb.sv */
// Testbench for the processor with a memory model, ISA reference model and random programs
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int SEED         = 70;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_INSTR    = 64;
    localparam int NUM_RANDOM   = 36;
    localparam int NUM_PROGS    = 40;
    localparam int POST_HALT    = 20;
    localparam int MAX_CYCLES   = NUM_PROGS * (MAX_INSTR * 8 + RESET_CYCLES + POST_HALT + 8);

    logic         clk = 1'b0;
    logic         rst_n = 1'b0;
    logic         en = 1'b0;
    word_t        mem_rdata = '0;
    mem_req_t     mem_req;
    logic         halt;
    cycle_count_t cc;
    word_t        mem [256];
    int           cycles = 0;

    `include "isa_model.svh"

    cpu_top #(.START_PC(RESET_PC)) dut (.clk, .rst_n, .en, .mem_rdata, .mem_req, .halt, .cc);

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic report_value(string msg);
        $display("** Error at time %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_store(word_t got_addr, word_t got_data, word_t want_addr,
                               word_t want_data);
        if (got_addr !== want_addr || got_data !== want_data)
            report_value($sformatf("store of %0d to %0d, expected %0d to %0d",
                                   got_data, got_addr, want_data, want_addr));
    endtask

    task automatic check_count(cycle_count_t got, cycle_count_t want, string what);
        if (got !== want)
            report_value($sformatf("%s is %0d, expected %0d", what, got, want));
    endtask

    task automatic check_request(mem_req_t got, word_t want_addr);
        if (got.write !== 1'b0 || got.addr !== want_addr)
            report_value($sformatf("first request write=%0b addr=%0d, expected read of %0d",
                                   got.write, got.addr, want_addr));
    endtask

    task automatic check_flag(logic got, logic want, string what);
        if (got !== want)
            report_value($sformatf("%s is %0b, expected %0b", what, got, want));
    endtask

    // Memory with one cycle read latency, writes checked against the model
    always @(posedge clk) begin
        if (mem_req.valid && mem_req.write) begin
            if (store_addr_q.size() == 0) begin
                $display("DUT wrote to address %0d after the last expected store", mem_req.addr);
                abort_run();
            end else begin
                check_store(mem_req.addr, mem_req.wdata, store_addr_q.pop_front(),
                            store_data_q.pop_front());
                mem[mem_req.addr] = mem_req.wdata;
            end
        end else if (mem_req.valid) begin
            mem_rdata <= mem[mem_req.addr];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // Fresh reset, start at en, wait for HALT and watch the halted state
    task automatic run_program();
        cycle_count_t final_cc;
        mem = image;
        rst_n <= 1'b0;
        en    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_flag(halt, 1'b0, "halt before start");
            check_flag(mem_req.valid, 1'b0, "request valid before start");
        end
        en <= 1'b1;
        do @(posedge clk); while (!mem_req.valid);
        check_request(mem_req, RESET_PC);
        while (!halt) @(posedge clk);
        check_count(cc, exp_count, "retired count at halt");
        if (store_addr_q.size() != 0) begin
            $display("DUT halted with %0d expected stores missing", store_addr_q.size());
            abort_run();
        end
        final_cc = cc;
        repeat (POST_HALT) begin
            @(posedge clk);
            check_flag(halt, 1'b1, "halt after HALT");
            check_flag(mem_req.valid, 1'b0, "request valid after HALT");
            check_count(cc, final_cc, "count after HALT");
        end
    endtask

    task automatic run_directed(string name);
        if (!run_model(MAX_INSTR)) begin
            $display("The %s program does not halt in the reference model", name);
            abort_run();
        end
        run_program();
    endtask

    initial begin
        void'($urandom(SEED));
        alu_program();
        run_directed("ALU");
        load_store_program();
        run_directed("load/store");
        branch_program();
        run_directed("control-flow");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            do
                random_program();
            while (!run_model(MAX_INSTR));  // Only programs that halt in time
            run_program();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
